// ==== rf_pkg.sv ====
package rf_pkg;

    // ============================================================
    // Word geometry
    // ============================================================

    // Two bits per trit, 18 trits per word
    localparam int trit_w     = 2;
    localparam int word_trits = 18;
    localparam int word_w     = trit_w * word_trits;
    localparam int addr_w     = 4;

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // Trit code 00 is zero, so a cleared word reads as ternary zero
    localparam word_t word_zero = '0;

    // ============================================================
    // State and error encodings
    // ============================================================

    // Numbering shared with the other processor blocks
    typedef enum logic [3:0] {
        st_idle  = 4'd0,
        st_read  = 4'd1,
        st_write = 4'd2,
        st_debug = 4'd3,
        st_error = 4'd15
    } rf_state_t;

    typedef enum logic [3:0] {
        err_none         = 4'd0,
        err_invalid_addr = 4'd1,
        err_collision    = 4'd2
    } rf_err_t;

    // ============================================================
    // Port bundles
    // ============================================================

    typedef struct packed {
        addr_t a;
        addr_t b;
        addr_t c;
    } rf_rd_req_t;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
    } rf_rd_data_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } rf_wr_req_t;

    // Address check results, all combinational
    typedef struct packed {
        logic rd_bad;
        logic wr_a_bad;
        logic wr_b_bad;
        logic dbg_bad;
        logic conflict;
    } rf_check_t;

    // Single-cycle strobes from the FSM
    typedef struct packed {
        logic do_read;
        logic wr_a;
        logic wr_b;
        logic do_debug;
    } rf_cmd_t;

endpackage

// ==== rf_addr_check.sv ====
`timescale 1ns/1ps

module rf_addr_check #(
    parameter int num_regs = 13
) (
    input  rf_pkg::rf_rd_req_t rd_req,
    input  rf_pkg::rf_wr_req_t wr_a,
    input  rf_pkg::rf_wr_req_t wr_b,
    input  rf_pkg::addr_t      debug_addr,
    output rf_pkg::rf_check_t  check
);

    // True when the address points past the last implemented register
    function automatic logic addr_bad(input rf_pkg::addr_t addr);
        return (int'(addr) >= num_regs);
    endfunction

    logic rd_a_bad;
    logic rd_b_bad;
    logic rd_c_bad;
    logic same_addr;

    // ============================================================
    // Read and debug ports
    // ============================================================

    // Every read port is checked, not only port a
    assign rd_a_bad = addr_bad(rd_req.a);
    assign rd_b_bad = addr_bad(rd_req.b);
    assign rd_c_bad = addr_bad(rd_req.c);

    assign check.rd_bad  = rd_a_bad | rd_b_bad | rd_c_bad;
    assign check.dbg_bad = addr_bad(debug_addr);

    // ============================================================
    // Write ports
    // ============================================================

    // A disabled port never flags, whatever its address holds
    assign check.wr_a_bad = wr_a.en & addr_bad(wr_a.addr);
    assign check.wr_b_bad = wr_b.en & addr_bad(wr_b.addr);

    assign same_addr = (wr_a.addr == wr_b.addr);

    // Both ports aiming at one register in the same operation
    assign check.conflict = wr_a.en & wr_b.en & same_addr;

endmodule

// ==== rf_ctrl.sv ====
`timescale 1ns/1ps

module rf_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                debug_enable,
    input  logic                wr_en_a,
    input  logic                wr_en_b,
    input  rf_pkg::rf_check_t   check,
    output rf_pkg::rf_cmd_t     cmd,
    output rf_pkg::rf_state_t   current_state,
    output logic                error,
    output rf_pkg::rf_err_t     error_code,
    output logic                write_conflict,
    output logic                invalid_address
);

    rf_pkg::rf_state_t next_state;
    logic              raise;
    rf_pkg::rf_err_t   raise_code;

    // ============================================================
    // Next state and strobe decode
    // ============================================================

    always_comb begin
        next_state = current_state;
        cmd        = '0;
        raise      = 1'b0;
        raise_code = rf_pkg::err_none;

        case (current_state)
            rf_pkg::st_idle: begin
                // Debug beats write, write beats read
                if (debug_enable) begin
                    next_state = rf_pkg::st_debug;
                end else if (wr_en_a || wr_en_b) begin
                    next_state = rf_pkg::st_write;
                end else begin
                    next_state = rf_pkg::st_read;
                end
            end

            rf_pkg::st_read: begin
                if (check.rd_bad) begin
                    raise      = 1'b1;
                    raise_code = rf_pkg::err_invalid_addr;
                end else begin
                    cmd.do_read = 1'b1;
                    next_state  = rf_pkg::st_idle;
                end
            end

            rf_pkg::st_write: begin
                if (check.conflict) begin
                    // Collision blocks both ports
                    raise      = 1'b1;
                    raise_code = rf_pkg::err_collision;
                end else if (check.wr_a_bad) begin
                    // Bad port a also skips port b
                    raise      = 1'b1;
                    raise_code = rf_pkg::err_invalid_addr;
                end else begin
                    cmd.wr_a = wr_en_a;
                    if (check.wr_b_bad) begin
                        // Port a still lands
                        raise      = 1'b1;
                        raise_code = rf_pkg::err_invalid_addr;
                    end else begin
                        cmd.wr_b   = wr_en_b;
                        next_state = rf_pkg::st_idle;
                    end
                end
            end

            rf_pkg::st_debug: begin
                if (check.dbg_bad) begin
                    raise      = 1'b1;
                    raise_code = rf_pkg::err_invalid_addr;
                end else begin
                    cmd.do_debug = 1'b1;
                    next_state   = rf_pkg::st_idle;
                end
            end

            rf_pkg::st_error: begin
                // Held here until rst_n
                next_state = rf_pkg::st_error;
            end

            default: next_state = rf_pkg::st_idle;
        endcase

        if (raise) begin
            next_state = rf_pkg::st_error;
        end
    end

    // ============================================================
    // State and sticky error flags
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_state   <= rf_pkg::st_idle;
            error           <= 1'b0;
            error_code      <= rf_pkg::err_none;
            write_conflict  <= 1'b0;
            invalid_address <= 1'b0;
        end else begin
            current_state <= next_state;
            if (raise) begin
                error      <= 1'b1;
                error_code <= raise_code;
                if (raise_code == rf_pkg::err_collision) begin
                    write_conflict <= 1'b1;
                end else begin
                    invalid_address <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rf_bank.sv ====
`timescale 1ns/1ps

module rf_bank #(
    parameter int num_regs = 13
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rf_pkg::rf_cmd_t      cmd,
    input  rf_pkg::rf_rd_req_t   rd_req,
    input  rf_pkg::rf_wr_req_t   wr_a,
    input  rf_pkg::rf_wr_req_t   wr_b,
    input  rf_pkg::addr_t        debug_addr,
    output rf_pkg::rf_rd_data_t  rd_data,
    output rf_pkg::word_t        debug_data
);

    // ============================================================
    // Register storage
    // ============================================================

    rf_pkg::word_t regs [num_regs];

    // Addresses are range checked upstream before any strobe fires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= rf_pkg::word_zero;
            end
        end else begin
            if (cmd.wr_a) begin
                regs[wr_a.addr] <= wr_a.data;
            end
            // Ports never share an address when both strobes are high
            if (cmd.wr_b) begin
                regs[wr_b.addr] <= wr_b.data;
            end
        end
    end

    // ============================================================
    // Read port outputs
    // ============================================================

    // All three words captured on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data.a <= rf_pkg::word_zero;
            rd_data.b <= rf_pkg::word_zero;
            rd_data.c <= rf_pkg::word_zero;
        end else if (cmd.do_read) begin
            rd_data.a <= regs[rd_req.a];
            rd_data.b <= regs[rd_req.b];
            rd_data.c <= regs[rd_req.c];
        end
    end

    // ============================================================
    // Debug port output
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_data <= rf_pkg::word_zero;
        end else if (cmd.do_debug) begin
            debug_data <= regs[debug_addr];
        end
    end

endmodule

// ==== rf_counters.sv ====
`timescale 1ns/1ps

module rf_counters #(
    parameter int count_w = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  rf_pkg::rf_cmd_t    cmd,
    output logic [count_w-1:0] read_count,
    output logic [count_w-1:0] write_count
);

    logic [count_w-1:0] rd_inc;
    logic [count_w-1:0] wr_inc;

    // ============================================================
    // Increment amounts
    // ============================================================

    // One per read operation
    assign rd_inc = count_w'(cmd.do_read);

    // Each written port counts, so a dual write adds two
    assign wr_inc = count_w'(cmd.wr_a) + count_w'(cmd.wr_b);

    // ============================================================
    // Counters
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_count <= '0;
        end else begin
            read_count <= read_count + rd_inc;
        end
    end

    // Wraps silently at the top of the range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_count <= '0;
        end else begin
            write_count <= write_count + wr_inc;
        end
    end

endmodule

// ==== rf_top.sv ====
`timescale 1ns/1ps

module rf_top #(
    parameter int num_regs = 13,
    parameter int count_w  = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Read ports
    input  rf_pkg::rf_rd_req_t   rd_req,
    output rf_pkg::rf_rd_data_t  rd_data,

    // Write ports
    input  rf_pkg::rf_wr_req_t   wr_a,
    input  rf_pkg::rf_wr_req_t   wr_b,

    // Debug port
    input  logic                 debug_enable,
    input  rf_pkg::addr_t        debug_addr,
    output rf_pkg::word_t        debug_data,

    // Error and status
    output logic                 error,
    output rf_pkg::rf_err_t      error_code,
    output logic                 write_conflict,
    output logic                 invalid_address,
    output rf_pkg::rf_state_t    current_state,
    output logic [count_w-1:0]   read_count,
    output logic [count_w-1:0]   write_count
);

    rf_pkg::rf_check_t check;
    rf_pkg::rf_cmd_t   cmd;

    // ============================================================
    // Address checks, combinational into the FSM
    // ============================================================

    rf_addr_check #(
        .num_regs (num_regs)
    ) u_addr_check (
        .rd_req     (rd_req),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .debug_addr (debug_addr),
        .check      (check)
    );

    rf_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .debug_enable    (debug_enable),
        .wr_en_a         (wr_a.en),
        .wr_en_b         (wr_b.en),
        .check           (check),
        .cmd             (cmd),
        .current_state   (current_state),
        .error           (error),
        .error_code      (error_code),
        .write_conflict  (write_conflict),
        .invalid_address (invalid_address)
    );

    // ============================================================
    // Storage and counters, both driven by the strobes
    // ============================================================

    rf_bank #(
        .num_regs (num_regs)
    ) u_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .rd_req     (rd_req),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .debug_addr (debug_addr),
        .rd_data    (rd_data),
        .debug_data (debug_data)
    );

    rf_counters #(
        .count_w (count_w)
    ) u_counters (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .read_count  (read_count),
        .write_count (write_count)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 8
) (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);

    logic por_n;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Power-on reset, released on a falling edge
    initial begin
        por_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        por_n = 1'b1;
    end

    assign rst_n = por_n & ~reset_req;

endmodule

// ==== tb_tasks.svh ====
    // ============================================================
    // Reference model and expected outputs
    // ============================================================

    rf_pkg::word_t       model_regs [num_regs];
    rf_pkg::rf_rd_data_t exp_rd;
    rf_pkg::word_t       exp_dbg;
    rf_pkg::rf_state_t   exp_state;
    rf_pkg::rf_err_t     exp_code;
    logic                exp_error;
    logic                exp_conflict;
    logic                exp_invalid;
    logic [count_w-1:0]  exp_reads;
    logic [count_w-1:0]  exp_writes;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_word(input string name, input rf_pkg::word_t exp,
                                input rf_pkg::word_t got);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_rd(input string name, input rf_pkg::rf_rd_data_t exp,
                              input rf_pkg::rf_rd_data_t got);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_state(input string name, input rf_pkg::rf_state_t exp,
                                 input rf_pkg::rf_state_t got);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_err(input string name, input rf_pkg::rf_err_t exp,
                               input rf_pkg::rf_err_t got);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_count(input string name, input logic [count_w-1:0] exp,
                                 input logic [count_w-1:0] got);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic got);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    // ============================================================
    // Stimulus helpers
    // ============================================================

    // Only legal trit codes 00, 01 and 10
    function automatic rf_pkg::word_t rand_word();
        rf_pkg::word_t w;
        int unsigned   t;
        w = rf_pkg::word_zero;
        for (int i = 0; i < rf_pkg::word_trits; i++) begin
            t = $urandom % 3;
            w[i*rf_pkg::trit_w +: rf_pkg::trit_w] = t[1:0];
        end
        return w;
    endfunction

    function automatic int rand_addr();
        return $urandom % num_regs;
    endfunction

    // Somewhere in 13 to 15
    function automatic int bad_addr();
        return num_regs + ($urandom % (16 - num_regs));
    endfunction

    function automatic rf_pkg::rf_rd_req_t make_rd(input int a, input int b, input int c);
        rf_pkg::rf_rd_req_t r;
        r.a = rf_pkg::addr_t'(a);
        r.b = rf_pkg::addr_t'(b);
        r.c = rf_pkg::addr_t'(c);
        return r;
    endfunction

    function automatic rf_pkg::rf_wr_req_t make_wr(input logic en, input int addr,
                                                   input rf_pkg::word_t data);
        rf_pkg::rf_wr_req_t w;
        w.en   = en;
        w.addr = rf_pkg::addr_t'(addr);
        w.data = data;
        return w;
    endfunction

    function automatic logic out_of_range(input rf_pkg::addr_t addr);
        return (int'(addr) >= num_regs);
    endfunction

    // ============================================================
    // Model update and output checks
    // ============================================================

    task automatic reset_model();
        for (int i = 0; i < num_regs; i++) model_regs[i] = rf_pkg::word_zero;
        exp_rd       = '0;
        exp_dbg      = rf_pkg::word_zero;
        exp_state    = rf_pkg::st_idle;
        exp_code     = rf_pkg::err_none;
        exp_error    = 1'b0;
        exp_conflict = 1'b0;
        exp_invalid  = 1'b0;
        exp_reads    = '0;
        exp_writes   = '0;
    endtask

    // Debug beats write, write beats read
    task automatic predict(input rf_pkg::rf_rd_req_t rd, input rf_pkg::rf_wr_req_t wa,
                           input rf_pkg::rf_wr_req_t wb, input logic dbg_en,
                           input rf_pkg::addr_t dbg_addr, output rf_pkg::rf_state_t op_state);
        rf_pkg::rf_err_t err;
        err = rf_pkg::err_none;
        if (dbg_en) begin
            op_state = rf_pkg::st_debug;
            if (out_of_range(dbg_addr)) err = rf_pkg::err_invalid_addr;
            else exp_dbg = model_regs[dbg_addr];
        end else if (wa.en || wb.en) begin
            op_state = rf_pkg::st_write;
            if (wa.en && wb.en && wa.addr == wb.addr) begin
                err = rf_pkg::err_collision;
            end else if (wa.en && out_of_range(wa.addr)) begin
                err = rf_pkg::err_invalid_addr;
            end else begin
                if (wa.en) begin
                    model_regs[wa.addr] = wa.data;
                    exp_writes = exp_writes + 1;
                end
                if (wb.en && out_of_range(wb.addr)) begin
                    err = rf_pkg::err_invalid_addr;
                end else if (wb.en) begin
                    model_regs[wb.addr] = wb.data;
                    exp_writes = exp_writes + 1;
                end
            end
        end else begin
            op_state = rf_pkg::st_read;
            if (out_of_range(rd.a) || out_of_range(rd.b) || out_of_range(rd.c)) begin
                err = rf_pkg::err_invalid_addr;
            end else begin
                exp_rd.a  = model_regs[rd.a];
                exp_rd.b  = model_regs[rd.b];
                exp_rd.c  = model_regs[rd.c];
                exp_reads = exp_reads + 1;
            end
        end
        if (err != rf_pkg::err_none) begin
            exp_state = rf_pkg::st_error;
            exp_error = 1'b1;
            exp_code  = err;
            if (err == rf_pkg::err_collision) exp_conflict = 1'b1;
            else exp_invalid = 1'b1;
        end
    endtask

    task automatic check_outputs();
        compare_state("current_state", exp_state, current_state);
        compare_flag("error", exp_error, error);
        compare_err("error_code", exp_code, error_code);
        compare_flag("write_conflict", exp_conflict, write_conflict);
        compare_flag("invalid_address", exp_invalid, invalid_address);
        compare_rd("rd_data", exp_rd, rd_data);
        compare_word("debug_data", exp_dbg, debug_data);
        compare_count("read_count", exp_reads, read_count);
        compare_count("write_count", exp_writes, write_count);
        for (int i = 0; i < num_regs; i++)
            compare_word($sformatf("regs[%0d]", i), model_regs[i], i_dut.u_bank.regs[i]);
    endtask

    // Starts and ends on a falling edge
    task automatic run_op(input rf_pkg::rf_rd_req_t rd, input rf_pkg::rf_wr_req_t wa,
                          input rf_pkg::rf_wr_req_t wb, input logic dbg_en, input int dbg);
        rf_pkg::rf_state_t op_state;
        while (current_state != rf_pkg::st_idle) @(negedge clk);
        rd_req       = rd;
        wr_a         = wa;
        wr_b         = wb;
        debug_enable = dbg_en;
        debug_addr   = rf_pkg::addr_t'(dbg);
        predict(rd, wa, wb, dbg_en, rf_pkg::addr_t'(dbg), op_state);
        @(negedge clk);
        compare_state("current_state", op_state, current_state);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic read_op(input int a, input int b, input int c);
        run_op(make_rd(a, b, c), '0, '0, 1'b0, 0);
    endtask

    task automatic write_op(input rf_pkg::rf_wr_req_t wa, input rf_pkg::rf_wr_req_t wb);
        run_op(make_rd(0, 0, 0), wa, wb, 1'b0, 0);
    endtask

    task automatic debug_op(input int addr);
        run_op(make_rd(0, 0, 0), '0, '0, 1'b1, addr);
    endtask

    // Error state must not decay on its own
    task automatic check_error_holds();
        repeat (4) @(negedge clk);
        check_outputs();
    endtask

    task automatic apply_reset();
        reset_req = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset_req = 1'b0;
        reset_model();
        check_outputs();
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_reset_reads();
        for (int i = 0; i < num_regs; i++)
            read_op(i, (i + 1) % num_regs, (i + 2) % num_regs);
        for (int i = 0; i < num_regs; i++) debug_op(i);
    endtask

    task automatic test_writes();
        int a;
        int b;
        for (int n = 0; n < 4; n++) begin
            a = rand_addr();
            b = (a + 1 + ($urandom % (num_regs - 1))) % num_regs;
            write_op(make_wr(1'b1, a, rand_word()), make_wr(1'b1, b, rand_word()));
        end
        write_op(make_wr(1'b1, rand_addr(), rand_word()), '0);
        write_op('0, make_wr(1'b1, rand_addr(), rand_word()));
        for (int i = 0; i < num_regs; i += 3)
            read_op(i, (i + 1) % num_regs, (i + 2) % num_regs);
    endtask

    task automatic test_debug_priority();
        int a;
        for (int n = 0; n < 3; n++) begin
            a = rand_addr();
            run_op(make_rd(0, 0, 0), make_wr(1'b1, a, rand_word()),
                   make_wr(1'b1, (a + 1) % num_regs, rand_word()), 1'b1, a);
        end
    endtask

    task automatic test_collision();
        int a;
        a = rand_addr();
        write_op(make_wr(1'b1, a, rand_word()), make_wr(1'b1, a, rand_word()));
        check_error_holds();
        apply_reset();
        debug_op(a);
    endtask

    task automatic test_invalid_addr();
        int a;
        for (int k = 0; k < 6; k++) begin
            a = rand_addr();
            // Non-zero output words, so a blocked update would show
            write_op(make_wr(1'b1, a, rand_word()), '0);
            read_op(a, a, a);
            debug_op(a);
            case (k)
                0: read_op(bad_addr(), a, a);
                1: read_op(a, bad_addr(), a);
                2: read_op(a, a, bad_addr());
                3: write_op(make_wr(1'b1, bad_addr(), rand_word()),
                            make_wr(1'b1, (a + 1) % num_regs, rand_word()));
                4: debug_op(bad_addr());
                default: write_op(make_wr(1'b1, (a + 1) % num_regs, rand_word()),
                                  make_wr(1'b1, bad_addr(), rand_word()));
            endcase
            check_error_holds();
            apply_reset();
        end
    endtask

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int num_regs     = 13;
    localparam int count_w      = 32;
    localparam int reset_cycles = 8;
    localparam int rand_seed    = 39268;

    // Power-on reset plus all directed tests, in clock cycles
    localparam int test_cycles    = 224;
    localparam int timeout_cycles = test_cycles * 4;

    logic                clk;
    logic                rst_n;
    logic                reset_req;
    rf_pkg::rf_rd_req_t  rd_req;
    rf_pkg::rf_rd_data_t rd_data;
    rf_pkg::rf_wr_req_t  wr_a;
    rf_pkg::rf_wr_req_t  wr_b;
    logic                debug_enable;
    rf_pkg::addr_t       debug_addr;
    rf_pkg::word_t       debug_data;
    logic                error;
    rf_pkg::rf_err_t     error_code;
    logic                write_conflict;
    logic                invalid_address;
    rf_pkg::rf_state_t   current_state;
    logic [count_w-1:0]  read_count;
    logic [count_w-1:0]  write_count;

    int cycle_count;

    tb_clk_gen #(
        .half_period  (4),
        .reset_cycles (reset_cycles)
    ) u_clk_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    rf_top #(
        .num_regs (num_regs),
        .count_w  (count_w)
    ) i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_req          (rd_req),
        .rd_data         (rd_data),
        .wr_a            (wr_a),
        .wr_b            (wr_b),
        .debug_enable    (debug_enable),
        .debug_addr      (debug_addr),
        .debug_data      (debug_data),
        .error           (error),
        .error_code      (error_code),
        .write_conflict  (write_conflict),
        .invalid_address (invalid_address),
        .current_state   (current_state),
        .read_count      (read_count),
        .write_count     (write_count)
    );

    `include "tb_tasks.svh"

    // ============================================================
    // Watchdog
    // ============================================================

    initial cycle_count = 0;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        reset_req    = 1'b0;
        rd_req       = '0;
        wr_a         = '0;
        wr_b         = '0;
        debug_enable = 1'b0;
        debug_addr   = '0;
        void'($urandom(rand_seed));
        reset_model();

        wait (rst_n === 1'b1);
        check_outputs();

        test_reset_reads();
        test_writes();
        test_debug_priority();
        test_collision();
        test_invalid_addr();

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
rf_pkg.sv
rf_addr_check.sv
rf_ctrl.sv
rf_bank.sv
rf_counters.sv
rf_top.sv
tb_clk_gen.sv
tb_top.sv
